/* hw/rom_load_pkg.sv */
`default_nettype none

package rom_load_pkg;

	// Bank 0 main CPU, bank 1 sub CPU, bank 2 sprites.
	localparam int NUM_BANKS = 3;

	localparam int REGION_BITS = 2;
	localparam int OFFSET_BITS = 10;
	localparam int ADDR_BITS = REGION_BITS + OFFSET_BITS;

	localparam int WORD_ADDR_BITS = OFFSET_BITS - 1;
	localparam int WORD_BITS = 16;

	// One extra bit so a full bank reads 1024.
	localparam int COUNT_BITS = OFFSET_BITS + 1;

	// Download address, flat or split into region and byte offset.
	typedef union packed {
		logic [ADDR_BITS-1:0] flat;
		struct packed {
			logic [REGION_BITS-1:0] region;
			logic [OFFSET_BITS-1:0] offset;
		} f;
	} dl_addr_u;

endpackage

`default_nettype wire

/* hw/dl_region_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module dl_region_decoder (
	input  logic                                  clock_48,
	input  logic                                  rst,
	input  logic                                  dl_active,
	input  logic                                  dl_wr,
	input  logic [rom_load_pkg::ADDR_BITS-1:0]    dl_addr,
	input  logic [7:0]                            dl_data,
	output logic [rom_load_pkg::NUM_BANKS-1:0]    bank_we,
	output logic [rom_load_pkg::WORD_ADDR_BITS-1:0] wr_word_addr,
	output logic                                  wr_lane,
	output logic [7:0]                            wr_byte
);

	import rom_load_pkg::*;

	dl_addr_u addr_v;
	logic strobe;
	logic [NUM_BANKS-1:0] region_hit;

	assign addr_v = dl_addr;
	assign strobe = dl_wr & dl_active; // Strobes outside a download are ignored.

	// Region 3 matches no bank and falls through.
	always_comb begin
		region_hit = '0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			if (strobe && addr_v.f.region == i[REGION_BITS-1:0])
				region_hit[i] = 1'b1;
		end
	end

	always_ff @(posedge clock_48) begin
		if (rst) begin
			bank_we <= '0;
		end else begin
			bank_we <= region_hit;
		end
	end

	// Payload, only refreshed on an accepted strobe.
	always_ff @(posedge clock_48) begin
		if (strobe) begin
			wr_word_addr <= addr_v.f.offset[OFFSET_BITS-1:1];
			wr_lane      <= addr_v.f.offset[0]; // Odd offset is the high byte.
			wr_byte      <= dl_data;
		end
	end

	a_we_onehot: assert property (
		@(posedge clock_48) disable iff (rst)
		$onehot0(bank_we)
	) else $error("dl_region_decoder: more than one bank enabled");

endmodule

`default_nettype wire

/* hw/rom_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_bank (
	input  logic                                    clock_48,
	input  logic                                    rst,
	input  logic                                    we,
	input  logic [rom_load_pkg::WORD_ADDR_BITS-1:0] word_addr,
	input  logic                                    lane,
	input  logic [7:0]                              wr_byte,
	input  logic [rom_load_pkg::WORD_ADDR_BITS-1:0] rd_addr,
	output logic [rom_load_pkg::WORD_BITS-1:0]      rd_data,
	output logic                                    wrote
);

	import rom_load_pkg::*;

	logic [WORD_BITS-1:0] mem [2**WORD_ADDR_BITS];

	// Byte lane write, same split as the SDRAM port data strobes.
	always_ff @(posedge clock_48) begin
		if (we) begin
			if (lane)
				mem[word_addr][WORD_BITS-1:8] <= wr_byte;
			else
				mem[word_addr][7:0] <= wr_byte;
		end
	end

	always_ff @(posedge clock_48) begin
		rd_data <= mem[rd_addr]; // One cycle latency.
	end

	// Tells the controller a byte landed.
	always_ff @(posedge clock_48) begin
		if (rst) begin
			wrote <= 1'b0;
		end else begin
			wrote <= we;
		end
	end

	a_wrote_follows_we: assert property (
		@(posedge clock_48) disable iff (rst)
		!we |=> !wrote
	) else $error("rom_bank: write pulse without a write");

endmodule

`default_nettype wire

/* hw/load_reset_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module load_reset_ctrl (
	input  logic                                    clock_48,
	input  logic                                    rst,
	input  logic                                    dl_active,
	input  logic                                    user_reset,
	input  logic [rom_load_pkg::NUM_BANKS-1:0]      bank_wrote,
	output logic [rom_load_pkg::NUM_BANKS-1:0][rom_load_pkg::COUNT_BITS-1:0] byte_count,
	output logic                                    rom_loaded,
	output logic                                    core_reset
);

	import rom_load_pkg::*;

	logic dl_active_d;
	logic dl_start;
	logic dl_end;

	assign dl_start = dl_active & ~dl_active_d;
	assign dl_end   = ~dl_active & dl_active_d;

	always_ff @(posedge clock_48) begin
		if (rst) begin
			dl_active_d <= 1'b0;
		end else begin
			dl_active_d <= dl_active;
		end
	end

	// Per bank byte counters, cleared when a new download begins.
	always_ff @(posedge clock_48) begin
		if (rst) begin
			byte_count <= '0;
		end else begin
			for (int i = 0; i < NUM_BANKS; i++) begin
				if (dl_start)
					byte_count[i] <= '0;
				else if (bank_wrote[i])
					byte_count[i] <= byte_count[i] + 1'b1;
			end
		end
	end

	// Sticky once the first download has finished.
	always_ff @(posedge clock_48) begin
		if (rst) begin
			rom_loaded <= 1'b0;
		end else if (dl_end) begin
			rom_loaded <= 1'b1;
		end
	end

	always_ff @(posedge clock_48) begin
		if (rst) begin
			core_reset <= 1'b1; // Core starts held.
		end else begin
			core_reset <= user_reset | dl_active | ~rom_loaded;
		end
	end

	a_loaded_sticky: assert property (
		@(posedge clock_48) disable iff (rst)
		rom_loaded |=> rom_loaded
	) else $error("load_reset_ctrl: rom_loaded dropped");

	a_reset_during_load: assert property (
		@(posedge clock_48) disable iff (rst)
		dl_active |=> core_reset
	) else $error("load_reset_ctrl: core released during download");

endmodule

`default_nettype wire

/* hw/rom_loader_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_loader_top (
	input  logic                                 clock_48,
	input  logic                                 rst,
	input  logic                                 dl_active,
	input  logic                                 dl_wr,
	input  logic [rom_load_pkg::ADDR_BITS-1:0]   dl_addr,
	input  logic [7:0]                           dl_data,
	input  logic                                 user_reset,
	input  logic [rom_load_pkg::NUM_BANKS-1:0][rom_load_pkg::WORD_ADDR_BITS-1:0] rd_addr,
	output logic [rom_load_pkg::NUM_BANKS-1:0][rom_load_pkg::WORD_BITS-1:0]      rd_data,
	output logic [rom_load_pkg::NUM_BANKS-1:0][rom_load_pkg::COUNT_BITS-1:0]     byte_count,
	output logic                                 rom_loaded,
	output logic                                 core_reset,
	output logic                                 led
);

	import rom_load_pkg::*;

	logic [NUM_BANKS-1:0]      bank_we;
	logic [WORD_ADDR_BITS-1:0] wr_word_addr;
	logic                      wr_lane;
	logic [7:0]                wr_byte;
	logic [NUM_BANKS-1:0]      bank_wrote;

	assign led = ~dl_active; // Lit when idle.

	dl_region_decoder decoder (
		.clock_48     (clock_48),
		.rst          (rst),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.bank_we      (bank_we),
		.wr_word_addr (wr_word_addr),
		.wr_lane      (wr_lane),
		.wr_byte      (wr_byte)
	);

	// Main CPU, sub CPU and sprite ROMs.
	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		rom_bank bank (
			.clock_48  (clock_48),
			.rst       (rst),
			.we        (bank_we[i]),
			.word_addr (wr_word_addr),
			.lane      (wr_lane),
			.wr_byte   (wr_byte),
			.rd_addr   (rd_addr[i]),
			.rd_data   (rd_data[i]),
			.wrote     (bank_wrote[i])
		);
	end

	load_reset_ctrl reset_ctrl (
		.clock_48   (clock_48),
		.rst        (rst),
		.dl_active  (dl_active),
		.user_reset (user_reset),
		.bank_wrote (bank_wrote),
		.byte_count (byte_count),
		.rom_loaded (rom_loaded),
		.core_reset (core_reset)
	);

endmodule

`default_nettype wire

/* test/rom_loader_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_loader_tb;

	import rom_load_pkg::*;

	localparam string STIM_FILE = "test/rom_loader_stim.txt";

	logic clock_48;
	logic rst;
	logic dl_active;
	logic dl_wr;
	logic [ADDR_BITS-1:0] dl_addr;
	logic [7:0] dl_data;
	logic user_reset;
	logic [NUM_BANKS-1:0][WORD_ADDR_BITS-1:0] rd_addr;
	logic [NUM_BANKS-1:0][WORD_BITS-1:0] rd_data;
	logic [NUM_BANKS-1:0][COUNT_BITS-1:0] byte_count;
	logic rom_loaded;
	logic core_reset;
	logic led;

	int cycle_count;
	int cycle_limit = 0;
	int error_count = 0;

	rom_loader_top rom_loader_top_inst (
		.clock_48   (clock_48),
		.rst        (rst),
		.dl_active  (dl_active),
		.dl_wr      (dl_wr),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.user_reset (user_reset),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.byte_count (byte_count),
		.rom_loaded (rom_loaded),
		.core_reset (core_reset),
		.led        (led)
	);

	initial begin
		clock_48 = 1'b0;
		forever #5 clock_48 = ~clock_48;
	end

	task automatic check_word(input logic [WORD_BITS-1:0] got,
			input logic [WORD_BITS-1:0] exp, input string what);
		if (got !== exp) begin
			error_count++;
			$display("ERROR at time %0t: %s read %h, expected %h", $time, what, got, exp);
			$display("Test failures found");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic check_count(input logic [COUNT_BITS-1:0] got,
			input logic [COUNT_BITS-1:0] exp, input string what);
		if (got !== exp) begin
			error_count++;
			$display("ERROR at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
			$display("Test failures found");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			error_count++;
			$display("ERROR at time %0t: %s is %b, expected %b", $time, what, got, exp);
			$display("Test failures found");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	// Let the write and reset pipelines drain, then sample away from the edge.
	task automatic settle();
		repeat (4) @(posedge clock_48);
		@(negedge clock_48);
	endtask

	task automatic write_byte(input logic [REGION_BITS-1:0] region,
			input logic [OFFSET_BITS-1:0] offset, input logic [7:0] data);
		dl_addr_u addr;
		addr.f.region = region;
		addr.f.offset = offset;
		@(posedge clock_48);
		dl_addr <= addr.flat;
		dl_data <= data;
		dl_wr   <= 1'b1;
		@(posedge clock_48);
		dl_wr   <= 1'b0; // Single cycle strobe.
	endtask

	function automatic bit is_op_line(input string line);
		if (line.len() == 0)
			return 1'b0;
		return line.getc(0) >= "A" && line.getc(0) <= "Z";
	endfunction

	task automatic run_line(input string line);
		byte op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		a = '0;
		b = '0;
		c = '0;
		void'($sscanf(line, "%c %h %h %h", op, a, b, c));
		case (op)
			"B": begin
				@(posedge clock_48);
				dl_active <= 1'b1;
			end
			"E": begin
				@(posedge clock_48);
				dl_active <= 1'b0;
			end
			"U": begin
				@(posedge clock_48);
				user_reset <= a[0];
			end
			"W": write_byte(a[REGION_BITS-1:0], b[OFFSET_BITS-1:0], c[7:0]);
			"R": begin
				@(posedge clock_48);
				rd_addr[a[1:0]] <= b[WORD_ADDR_BITS-1:0];
				settle();
				check_word(rd_data[a[1:0]], c[WORD_BITS-1:0],
					$sformatf("bank %0d word %h", a, b[WORD_ADDR_BITS-1:0]));
			end
			"C": begin
				settle();
				check_count(byte_count[a[1:0]], b[COUNT_BITS-1:0],
					$sformatf("byte_count of bank %0d", a));
			end
			"F": begin
				settle();
				check_flag(rom_loaded, a[0], "rom_loaded");
				check_flag(core_reset, b[0], "core_reset");
				check_flag(led, ~dl_active, "led"); // Dark while a download runs.
			end
			default: begin
				$display("Unknown operation in stimulus line: %s", line);
				$display("Test failures found");
				$fatal(1, "Bad stimulus file");
			end
		endcase
	endtask

	// Watchdog, armed once the stimulus length is known.
	initial begin
		cycle_count = 0;
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clock_48);
			cycle_count++;
		end
		$display("Simulation timed out after %0d cycles", cycle_count);
		$display("Test failures found");
		$fatal(1, "Watchdog limit reached");
	end

	initial begin
		int fd;
		int line_total;
		string line;
		rst        = 1'b1;
		dl_active  = 1'b0;
		dl_wr      = 1'b0;
		dl_addr    = '0;
		dl_data    = '0;
		user_reset = 1'b0;
		rd_addr    = '0;

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Could not open stimulus file %s", STIM_FILE);
			$display("Test failures found");
			$fatal(1, "Missing stimulus");
		end
		line_total = 0;
		while ($fgets(line, fd) != 0) begin
			if (is_op_line(line))
				line_total++;
		end
		$fclose(fd);
		cycle_limit = 40 * line_total + 200;

		repeat (10) @(posedge clock_48);
		rst <= 1'b0;

		fd = $fopen(STIM_FILE, "r");
		while ($fgets(line, fd) != 0) begin
			if (is_op_line(line))
				run_line(line);
		end
		$fclose(fd);

		repeat (2) @(posedge clock_48);
		if (error_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
hw/rom_load_pkg.sv
hw/dl_region_decoder.sv
hw/rom_bank.sv
hw/load_reset_ctrl.sv
hw/rom_loader_top.sv
test/rom_loader_tb.sv

/* Makefile */
# Verilator build and run for the ROM loader testbench.

SHELL := /bin/bash
SIM := obj_dir/rom_loader_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module rom_loader_tb \
		-f flist.f -o rom_loader_sim

run: compile
	set -o pipefail; ./$(SIM) 2>&1 | tee sim.log
	@if grep -q "Test failures found" sim.log; then \
		echo "Simulation FAILED"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

/* test/rom_loader_stim.txt */
# Op then hex operands: W region offset data, B start, E end, U level,
# R bank word expected, C bank count, F rom_loaded core_reset.
F 0 1
C 0 000
C 1 000
C 2 000
B
F 0 1
W 0 000 34
W 0 001 12
W 0 002 78
W 0 003 56
W 1 000 cd
W 1 001 ab
W 1 3fe 0f
W 1 3ff f0
W 2 010 11
W 2 011 22
W 3 000 ee
W 3 011 ee
C 0 004
C 1 004
C 2 002
E
F 1 0
W 0 000 99
W 2 010 99
R 0 000 1234
R 0 001 5678
R 1 000 abcd
R 1 1ff f00f
R 2 008 2211
C 0 004
C 1 004
C 2 002
U 1
F 1 1
U 0
F 1 0
B
C 0 000
C 1 000
C 2 000
F 1 1
W 0 000 aa
W 2 011 bb
W 1 001 ee
W 3 001 55
C 0 001
C 1 001
C 2 001
E
F 1 0
R 0 000 12aa
R 0 001 5678
R 2 008 bb11
R 1 000 eecd
R 1 1ff f00f
C 0 001
C 1 001
C 2 001
